// File: compile.f
+incdir+hdl
hdl/pic_pkg.sv
hdl/pic_cmd_decoder.sv
hdl/pic_request_reg.sv
hdl/pic_in_service.sv
hdl/pic_ack_ctrl.sv
hdl/pic_top.sv
tb/tb_pic.sv

// File: Makefile
SOURCES := $(shell grep -v '^+' compile.f) hdl/pic_defs.svh

.PHONY: all run clean

all: obj_dir/Vtb_pic

obj_dir/Vtb_pic: compile.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module tb_pic -f compile.f

run: obj_dir/Vtb_pic
	@out="$$(./obj_dir/Vtb_pic 2>&1)"; echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: tb/tb_pic.sv
`include "pic_defs.svh"

module tb_pic;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_tests = 6;

	logic clk;
	logic rst;
	pic_pkg::host_bus_t bus;
	pic_pkg::irq_vec_t irq;
	logic inta_n;
	logic [`PIC_DATA_W-1:0] data_out;
	logic data_oe;
	logic intr;

	pic_top i_dut (
		.clk      (clk),
		.rst      (rst),
		.bus      (bus),
		.irq      (irq),
		.inta_n   (inta_n),
		.data_out (data_out),
		.data_oe  (data_oe),
		.intr     (intr)
	);

	initial
		clk = 1'b0;

	always #5 clk = ~clk;

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(string name, logic [`PIC_DATA_W-1:0] exp,
			logic [`PIC_DATA_W-1:0] got);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_bit(string name, logic exp, logic got);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	task automatic check_vec(string name, pic_pkg::irq_vec_t exp, pic_pkg::irq_vec_t got);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s expected %b got %b", $time, name, exp, got);
			abort_run();
		end
	endtask

	function automatic pic_pkg::irq_vec_t one_hot(int level);
		one_hot = '0;
		one_hot[level] = 1'b1;
	endfunction

	task automatic idle_cycles(int n);
		repeat (n) @(posedge clk);
	endtask

	// Drops every request line long enough for a clean edge afterwards.
	task automatic clear_lines();
		@(posedge clk);
		irq <= '0;
		inta_n <= 1'b1;
		idle_cycles(2);
	endtask

	task automatic wait_intr();
		int n;
		n = 0;
		@(negedge clk);
		while (!intr && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (!intr)
		begin
			$display("Timeout at %0t: intr never went high", $time);
			abort_run();
		end
	endtask

	task automatic wait_data_oe(output logic [`PIC_DATA_W-1:0] value);
		int n;
		n = 0;
		@(negedge clk);
		while (!data_oe && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (!data_oe)
		begin
			$display("Timeout at %0t: data_oe never went high", $time);
			abort_run();
		end
		value = data_out;
	endtask

	task automatic write_reg(logic a0, logic [`PIC_DATA_W-1:0] data);
		@(posedge clk);
		bus <= '{wr: 1'b1, rd: 1'b0, a0: a0, data: data};
		@(posedge clk);
		bus <= '0;
	endtask

	task automatic read_reg(logic a0, output logic [`PIC_DATA_W-1:0] value);
		@(posedge clk);
		bus <= '{wr: 1'b0, rd: 1'b1, a0: a0, data: '0};
		@(posedge clk);
		bus <= '0;
		wait_data_oe(value);
		// Read data is driven for exactly one cycle.
		@(negedge clk);
		check_bit("data_oe", 1'b0, data_oe);
	endtask

	// Two INTA pulses with the vector on the bus during the second one.
	task automatic inta_pulse(output logic [`PIC_DATA_W-1:0] vector);
		@(posedge clk);
		inta_n <= 1'b0;
		idle_cycles(2);
		inta_n <= 1'b1;
		idle_cycles(2);
		inta_n <= 1'b0;
		wait_data_oe(vector);
		@(posedge clk);
		inta_n <= 1'b1;
		idle_cycles(3);
		@(negedge clk);
		check_bit("data_oe", 1'b0, data_oe);
	endtask

	task automatic init_pic(logic [4:0] base, logic level_mode, logic aeoi);
		write_reg(1'b0, {3'b000, 1'b1, level_mode, 2'b00, aeoi});
		write_reg(1'b1, {base, 3'b000});
		if (aeoi)
			write_reg(1'b1, 8'h03);
		idle_cycles(2);
	endtask

	task automatic basic_ack();
		logic [4:0] base;
		int level;
		logic [`PIC_DATA_W-1:0] value;
		base = 5'($urandom);
		level = $urandom % 8;
		clear_lines();
		init_pic(base, 1'b0, 1'b0);
		@(negedge clk);
		check_bit("intr", 1'b0, intr);
		@(posedge clk);
		irq <= one_hot(level);
		wait_intr();
		inta_pulse(value);
		check_data("vector", {base, 3'(level)}, value);
		write_reg(1'b0, 8'h0b);
		read_reg(1'b0, value);
		check_vec("isr", one_hot(level), value);
	endtask

	task automatic mask_select();
		logic [4:0] base;
		pic_pkg::irq_vec_t mask;
		int lowest;
		logic [`PIC_DATA_W-1:0] value;
		base = 5'($urandom);
		mask = 8'($urandom);
		if (mask == 8'hff)
			mask = 8'hfe;
		lowest = 0;
		while (mask[lowest])
			lowest++;
		clear_lines();
		init_pic(base, 1'b0, 1'b0);
		write_reg(1'b1, mask);
		@(posedge clk);
		irq <= 8'hff;
		wait_intr();
		inta_pulse(value);
		check_data("vector", {base, 3'(lowest)}, value);
		read_reg(1'b1, value);
		check_vec("mask", mask, value);
	endtask

	task automatic nested_eoi();
		logic [4:0] base;
		int first_lvl;
		int second_lvl;
		logic [`PIC_DATA_W-1:0] value;
		base = 5'($urandom);
		first_lvl = $urandom % 7;
		second_lvl = first_lvl + 1 + int'($urandom % (7 - first_lvl));
		clear_lines();
		init_pic(base, 1'b0, 1'b0);
		@(posedge clk);
		irq <= one_hot(first_lvl) | one_hot(second_lvl);
		wait_intr();
		inta_pulse(value);
		check_data("vector", {base, 3'(first_lvl)}, value);
		// The lower level waits while the higher one is in service.
		@(negedge clk);
		check_bit("intr", 1'b0, intr);
		write_reg(1'b0, 8'h20);
		wait_intr();
		inta_pulse(value);
		check_data("vector", {base, 3'(second_lvl)}, value);
		write_reg(1'b0, 8'h0b);
		read_reg(1'b0, value);
		check_vec("isr", one_hot(second_lvl), value);
		write_reg(1'b0, 8'h60 | 8'(second_lvl));
		read_reg(1'b0, value);
		check_vec("isr", '0, value);
	endtask

	task automatic auto_eoi_ack();
		logic [4:0] base;
		int level;
		logic [`PIC_DATA_W-1:0] value;
		base = 5'($urandom);
		level = $urandom % 8;
		clear_lines();
		init_pic(base, 1'b0, 1'b1);
		@(posedge clk);
		irq <= one_hot(level);
		wait_intr();
		inta_pulse(value);
		check_data("vector", {base, 3'(level)}, value);
		write_reg(1'b0, 8'h0b);
		read_reg(1'b0, value);
		check_vec("isr", '0, value);
	endtask

	task automatic poll_spurious();
		logic [4:0] base;
		logic [`PIC_DATA_W-1:0] value;
		base = 5'($urandom);
		clear_lines();
		init_pic(base, 1'b0, 1'b0);
		@(negedge clk);
		check_bit("intr", 1'b0, intr);
		inta_pulse(value);
		check_data("vector", {base, 3'd7}, value);
		write_reg(1'b0, 8'h0c);
		read_reg(1'b0, value);
		check_data("poll", 8'h00, value);
		@(posedge clk);
		irq <= one_hot(5);
		wait_intr();
		write_reg(1'b0, 8'h0c);
		read_reg(1'b0, value);
		check_data("poll", {1'b1, 4'b0000, 3'd5}, value);
		write_reg(1'b0, 8'h0b);
		read_reg(1'b0, value);
		check_vec("isr", one_hot(5), value);
	endtask

	task automatic level_capture();
		logic [4:0] base;
		int level;
		logic [`PIC_DATA_W-1:0] value;
		base = 5'($urandom);
		level = $urandom % 8;
		clear_lines();
		init_pic(base, 1'b1, 1'b0);
		@(posedge clk);
		irq <= one_hot(level);
		wait_intr();
		write_reg(1'b0, 8'h0a);
		read_reg(1'b0, value);
		check_vec("irr", one_hot(level), value);
		idle_cycles(4);
		read_reg(1'b0, value);
		check_vec("irr", one_hot(level), value);
		@(posedge clk);
		irq <= '0;
		idle_cycles(2);
		read_reg(1'b0, value);
		check_vec("irr", '0, value);
	endtask

	initial
	begin
		#(num_tests * 2000);
		$display("Timeout: the run took longer than %0d ns", num_tests * 2000);
		abort_run();
	end

	initial
	begin
		void'($urandom(4429));
		rst = 1'b1;
		bus = '0;
		irq = '0;
		inta_n = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		idle_cycles(2);
		@(negedge clk);
		check_bit("intr", 1'b0, intr);
		check_bit("data_oe", 1'b0, data_oe);
		basic_ack();
		mask_select();
		nested_eoi();
		auto_eoi_ack();
		poll_spurious();
		level_capture();
		$display("Everything OK");
		$finish;
	end

endmodule

// File: hdl/pic_top.sv
`include "pic_defs.svh"

module pic_top (
	input  logic                   clk,
	input  logic                   rst,
	input  pic_pkg::host_bus_t     bus,
	input  pic_pkg::irq_vec_t      irq,
	input  logic                   inta_n,
	output logic [`PIC_DATA_W-1:0] data_out,
	output logic                   data_oe,
	output logic                   intr
);

	pic_pkg::pic_cfg_t cfg;
	pic_pkg::irq_vec_t mask;
	pic_pkg::irq_vec_t irr;
	pic_pkg::irq_vec_t isr;
	pic_pkg::irq_vec_t irr_clear;
	pic_pkg::eoi_req_t eoi;
	pic_pkg::ocw3_req_t ocw3;
	pic_pkg::winner_t winner;
	pic_pkg::ack_evt_t ack_seq;
	pic_pkg::ack_evt_t ack;
	logic icw1;

	// ICW1 resets the in-service register along with the sequence events.
	assign ack = '{take: ack_seq.take, finish: ack_seq.finish, init: icw1};

	pic_cmd_decoder i_cmd_decoder (
		.clk  (clk),
		.rst  (rst),
		.bus  (bus),
		.cfg  (cfg),
		.mask (mask),
		.eoi  (eoi),
		.ocw3 (ocw3),
		.icw1 (icw1)
	);

	pic_request_reg i_request_reg (
		.clk        (clk),
		.rst        (rst),
		.irq        (irq),
		.level_mode (cfg.level_mode),
		.init       (icw1),
		.irr_clear  (irr_clear),
		.irr        (irr)
	);

	pic_in_service i_in_service (
		.clk       (clk),
		.rst       (rst),
		.irr       (irr),
		.mask      (mask),
		.cfg       (cfg),
		.eoi       (eoi),
		.ack       (ack),
		.winner    (winner),
		.isr       (isr),
		.irr_clear (irr_clear),
		.intr      (intr)
	);

	pic_ack_ctrl i_ack_ctrl (
		.clk      (clk),
		.rst      (rst),
		.bus      (bus),
		.inta_n   (inta_n),
		.cfg      (cfg),
		.ocw3     (ocw3),
		.winner   (winner),
		.irr      (irr),
		.isr      (isr),
		.mask     (mask),
		.ack      (ack_seq),
		.data_out (data_out),
		.data_oe  (data_oe)
	);

endmodule

// File: hdl/pic_ack_ctrl.sv
`include "pic_defs.svh"

module pic_ack_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  pic_pkg::host_bus_t     bus,
	input  logic                   inta_n,
	input  pic_pkg::pic_cfg_t      cfg,
	input  pic_pkg::ocw3_req_t     ocw3,
	input  pic_pkg::winner_t       winner,
	input  pic_pkg::irq_vec_t      irr,
	input  pic_pkg::irq_vec_t      isr,
	input  pic_pkg::irq_vec_t      mask,
	output pic_pkg::ack_evt_t      ack,
	output logic [`PIC_DATA_W-1:0] data_out,
	output logic                   data_oe
);

	pic_pkg::ack_state_e state;
	pic_pkg::ack_state_e state_next;
	pic_pkg::level_t lat_level;
	logic inta_s;
	logic inta_prev;
	logic inta_fall;
	logic inta_rise;
	logic read_isr;
	logic rd_valid;
	logic vec_oe;
	logic [`PIC_DATA_W-1:0] rd_data;
	logic [`PIC_DATA_W-1:0] rd_word;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			inta_s    <= 1'b1;
			inta_prev <= 1'b1;
		end
		else
		begin
			inta_s    <= inta_n;
			inta_prev <= inta_s;
		end
	end

	assign inta_fall = inta_prev & ~inta_s;
	assign inta_rise = ~inta_prev & inta_s;

	// Two INTA pulses per acknowledge, poll is left by the next read.
	always_comb
	begin
		state_next = state;
		ack        = '0;
		case (state)
			pic_pkg::ack_idle:
				if (inta_fall)
				begin
					state_next = pic_pkg::ack_first;
					ack.take   = 1'b1;
				end
				else if (ocw3.poll)
					state_next = pic_pkg::ack_poll;
			pic_pkg::ack_first:
				if (inta_rise)
					state_next = pic_pkg::ack_second;
			pic_pkg::ack_second:
				if (inta_rise)
				begin
					state_next = pic_pkg::ack_idle;
					ack.finish = 1'b1;
				end
			pic_pkg::ack_poll:
				if (bus.rd)
				begin
					state_next = pic_pkg::ack_idle;
					ack.take   = 1'b1;
				end
			default:
				state_next = pic_pkg::ack_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= pic_pkg::ack_idle;
		else
			state <= state_next;
	end

	// Spurious acknowledge reports level 7.
	always_ff @(posedge clk)
	begin
		if (state == pic_pkg::ack_idle && inta_fall)
			lat_level <= winner.valid ? winner.level : '1;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			read_isr <= 1'b0;
		else if (ocw3.sel_valid)
			read_isr <= ocw3.read_isr;
	end

	always_comb
	begin
		rd_word = '0;
		if (state == pic_pkg::ack_poll)
		begin
			if (winner.valid)
			begin
				rd_word[`PIC_POLL_BIT]      = 1'b1;
				rd_word[`PIC_LEVEL_W-1:0] = winner.level;
			end
		end
		else if (bus.a0)
			rd_word = mask;
		else if (read_isr)
			rd_word = isr;
		else
			rd_word = irr;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= bus.rd;
	end

	always_ff @(posedge clk)
	begin
		if (bus.rd)
			rd_data <= rd_word;
	end

	assign vec_oe   = (state == pic_pkg::ack_second) && !inta_s;
	assign data_oe  = vec_oe | rd_valid;
	assign data_out = vec_oe ? {cfg.vector_base, lat_level} : rd_data;

endmodule

// File: hdl/pic_in_service.sv
`include "pic_defs.svh"

module pic_in_service (
	input  logic              clk,
	input  logic              rst,
	input  pic_pkg::irq_vec_t irr,
	input  pic_pkg::irq_vec_t mask,
	input  pic_pkg::pic_cfg_t cfg,
	input  pic_pkg::eoi_req_t eoi,
	input  pic_pkg::ack_evt_t ack,
	output pic_pkg::winner_t  winner,
	output pic_pkg::irq_vec_t isr,
	output pic_pkg::irq_vec_t irr_clear,
	output logic              intr
);

	pic_pkg::irq_vec_t req;
	pic_pkg::irq_vec_t hi_isr;
	pic_pkg::irq_vec_t take_vec;
	pic_pkg::irq_vec_t clr_vec;
	logic blocked;

	assign req = irr & ~mask;

	// Lowest set bit, which is the highest level in service.
	assign hi_isr = isr & (~isr + 1'b1);

	// Fixed priority, a level in service blocks itself and everything below.
	always_comb
	begin
		winner  = '0;
		blocked = 1'b0;
		for (int i = 0; i < `PIC_NUM_IRQ; i++)
		begin
			if (!blocked && isr[i])
				blocked = 1'b1;
			else if (!blocked && req[i])
			begin
				winner.valid = 1'b1;
				winner.level = pic_pkg::level_t'(i);
				blocked      = 1'b1;
			end
		end
	end

	always_comb
	begin
		take_vec = '0;
		clr_vec  = '0;
		if (ack.take && winner.valid)
			take_vec[winner.level] = 1'b1;
		if (eoi.valid && eoi.specific)
			clr_vec[eoi.level] = 1'b1;
		else if (eoi.valid || (ack.finish && cfg.auto_eoi))
			clr_vec = hi_isr;
	end

	assign irr_clear = take_vec;

	always_ff @(posedge clk)
	begin
		if (rst || ack.init)
			isr <= '0;
		else
			isr <= (isr | take_vec) & ~clr_vec;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			intr <= 1'b0;
		else
			intr <= cfg.ready && winner.valid;
	end

endmodule

// File: hdl/pic_request_reg.sv
`include "pic_defs.svh"

module pic_request_reg (
	input  logic              clk,
	input  logic              rst,
	input  pic_pkg::irq_vec_t irq,
	input  logic              level_mode,
	input  logic              init,
	input  pic_pkg::irq_vec_t irr_clear,
	output pic_pkg::irq_vec_t irr
);

	pic_pkg::irq_vec_t irq_prev;
	pic_pkg::irq_vec_t irq_rise;
	pic_pkg::irq_vec_t irr_next;

	assign irq_rise = irq & ~irq_prev;

	// Edge mode latches rising edges, level mode tracks the lines.
	always_comb
	begin
		if (level_mode)
			irr_next = irq;
		else
			irr_next = irr | irq_rise;
		irr_next = irr_next & ~irr_clear;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			irq_prev <= '0;
			irr      <= '0;
		end
		else
		begin
			irq_prev <= irq;
			irr      <= irr_next & {`PIC_NUM_IRQ{~init}};
		end
	end

endmodule

// File: hdl/pic_cmd_decoder.sv
`include "pic_defs.svh"

module pic_cmd_decoder (
	input  logic               clk,
	input  logic               rst,
	input  pic_pkg::host_bus_t bus,
	output pic_pkg::pic_cfg_t  cfg,
	output pic_pkg::irq_vec_t  mask,
	output pic_pkg::eoi_req_t  eoi,
	output pic_pkg::ocw3_req_t ocw3,
	output logic               icw1
);

	pic_pkg::cmd_kind_e kind;
	logic wait_icw2;
	logic wait_icw4;
	logic need_icw4;
	logic ready;
	logic level_mode;
	logic auto_eoi;
	logic [`PIC_DATA_W-`PIC_LEVEL_W-1:0] vector_base;
	logic [2:0] ocw2_code;

	assign ocw2_code = bus.data[7:5];

	// ICW1 is recognised at any time, the other words depend on the sequence.
	always_comb
	begin
		kind = pic_pkg::cmd_none;
		if (bus.wr)
		begin
			if (!bus.a0 && bus.data[4])
				kind = pic_pkg::cmd_icw1;
			else if (bus.a0 && wait_icw2)
				kind = pic_pkg::cmd_icw2;
			else if (bus.a0 && wait_icw4)
				kind = pic_pkg::cmd_icw4;
			else if (ready && bus.a0)
				kind = pic_pkg::cmd_ocw1;
			else if (ready && bus.data[3])
				kind = pic_pkg::cmd_ocw3;
			else if (ready)
				kind = pic_pkg::cmd_ocw2;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wait_icw2  <= 1'b0;
			wait_icw4  <= 1'b0;
			need_icw4  <= 1'b0;
			ready      <= 1'b0;
			level_mode <= 1'b0;
			auto_eoi   <= 1'b0;
			mask       <= '0;
		end
		else
		begin
			case (kind)
				pic_pkg::cmd_icw1:
				begin
					wait_icw2  <= 1'b1;
					wait_icw4  <= 1'b0;
					need_icw4  <= bus.data[0];
					ready      <= 1'b0;
					level_mode <= bus.data[3];
					auto_eoi   <= 1'b0;
					mask       <= '0;
				end
				pic_pkg::cmd_icw2:
				begin
					wait_icw2 <= 1'b0;
					wait_icw4 <= need_icw4;
					ready     <= ~need_icw4;
				end
				pic_pkg::cmd_icw4:
				begin
					wait_icw4 <= 1'b0;
					auto_eoi  <= bus.data[1];
					ready     <= 1'b1;
				end
				pic_pkg::cmd_ocw1:
					mask <= bus.data;
				default:
					mask <= mask;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (kind == pic_pkg::cmd_icw2)
			vector_base <= bus.data[`PIC_DATA_W-1:`PIC_LEVEL_W];
	end

	// Single-cycle requests to the service and acknowledge logic.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			icw1 <= 1'b0;
			eoi  <= '0;
			ocw3 <= '0;
		end
		else
		begin
			icw1           <= (kind == pic_pkg::cmd_icw1);
			eoi.valid      <= (kind == pic_pkg::cmd_ocw2) &&
					  (ocw2_code == 3'b001 || ocw2_code == 3'b011);
			eoi.specific   <= ocw2_code[1];
			eoi.level      <= bus.data[`PIC_LEVEL_W-1:0];
			ocw3.sel_valid <= (kind == pic_pkg::cmd_ocw3) && bus.data[1];
			ocw3.read_isr  <= bus.data[0];
			ocw3.poll      <= (kind == pic_pkg::cmd_ocw3) && bus.data[2];
		end
	end

	assign cfg = '{
		ready:       ready,
		level_mode:  level_mode,
		auto_eoi:    auto_eoi,
		vector_base: vector_base
	};

endmodule

// File: hdl/pic_pkg.sv
`include "pic_defs.svh"

package pic_pkg;

	typedef logic [`PIC_NUM_IRQ-1:0] irq_vec_t;
	typedef logic [`PIC_LEVEL_W-1:0] level_t;

	// One host bus cycle, wr and rd are single-cycle strobes.
	typedef struct packed {
		logic                   wr;
		logic                   rd;
		logic                   a0;
		logic [`PIC_DATA_W-1:0] data;
	} host_bus_t;

	typedef enum logic [2:0] {
		cmd_none,
		cmd_icw1,
		cmd_icw2,
		cmd_icw4,
		cmd_ocw1,
		cmd_ocw2,
		cmd_ocw3
	} cmd_kind_e;

	typedef struct packed {
		logic                                ready;
		logic                                level_mode;
		logic                                auto_eoi;
		logic [`PIC_DATA_W-`PIC_LEVEL_W-1:0] vector_base;
	} pic_cfg_t;

	typedef struct packed {
		logic   valid;
		logic   specific;
		level_t level;
	} eoi_req_t;

	typedef struct packed {
		logic sel_valid;
		logic read_isr;
		logic poll;
	} ocw3_req_t;

	typedef struct packed {
		logic   valid;
		level_t level;
	} winner_t;

	typedef struct packed {
		logic take;
		logic finish;
		logic init;
	} ack_evt_t;

	typedef enum logic [1:0] {
		ack_idle,
		ack_first,
		ack_second,
		ack_poll
	} ack_state_e;

endpackage

// File: hdl/pic_defs.svh
`ifndef PIC_DEFS_SVH
`define PIC_DEFS_SVH

// Number of interrupt request lines.
`define PIC_NUM_IRQ 8

// Width of an interrupt level number.
`define PIC_LEVEL_W 3

// Width of the host data bus.
`define PIC_DATA_W 8

// Interrupt present flag in the poll word.
`define PIC_POLL_BIT 7

`endif
